//--- source/core_mem_pkg.sv
package core_mem_pkg;

    // ************************************************************
    // widths
    // ************************************************************
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [31:0] inst_t;
    typedef logic [7:0]  strb_t;

    // access size code as log2 of the byte count
    typedef logic [1:0]  lsu_size_t;

    localparam lsu_size_t SIZE_BYTE   = 2'd0;
    localparam lsu_size_t SIZE_HALF   = 2'd1;
    localparam lsu_size_t SIZE_WORD   = 2'd2;
    localparam lsu_size_t SIZE_DOUBLE = 2'd3;

    // ************************************************************
    // wishbone classic master and slave sides
    // ************************************************************
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        strb_t sel;
        data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        data_t dat;
    } wb_rsp_t;

    // one load or store from the pipeline
    typedef struct packed {
        logic      we;
        lsu_size_t size;
        logic      unsigned_ld;
        addr_t     addr;
        data_t     wdata;
    } lsu_req_t;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_out_t;

    // fsm states
    typedef enum logic [1:0] {FETCH_IDLE, FETCH_BUS, FETCH_HOLD} fetch_state_e;
    typedef enum logic [1:0] {LSU_IDLE, LSU_BUS, LSU_RESP} lsu_state_e;
    typedef enum logic [1:0] {ARB_IDLE, ARB_FETCH, ARB_DATA} arb_state_e;

endpackage

//--- source/fetch_unit.sv
module fetch_unit #(
    parameter core_mem_pkg::addr_t RESET_PC = 32'h8000_0000
) (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     redirect_valid_i,
    input  core_mem_pkg::addr_t      redirect_pc_i,
    input  logic                     inst_ready_i,
    input  core_mem_pkg::wb_rsp_t    wb_i,
    output logic                     inst_valid_o,
    output core_mem_pkg::fetch_out_t fetch_o,
    output core_mem_pkg::wb_req_t    wb_o
);

    core_mem_pkg::fetch_state_e state_q;
    core_mem_pkg::addr_t        pc_q;
    core_mem_pkg::addr_t        redir_pc_q;
    logic                       redir_pend_q;
    core_mem_pkg::inst_t        inst_q;
    core_mem_pkg::inst_t        ack_inst;
    logic                       bus_done;
    logic                       flush;
    core_mem_pkg::addr_t        flush_pc;

    assign bus_done = (state_q == core_mem_pkg::FETCH_BUS) && wb_i.ack;
    // pc bit 2 picks the half of the double word
    assign ack_inst = pc_q[2] ? wb_i.dat[63:32] : wb_i.dat[31:0];
    // redirect now or earlier during this read
    assign flush    = redirect_valid_i || redir_pend_q;
    assign flush_pc = redirect_valid_i ? redirect_pc_i : redir_pc_q;

    // ************************************************************
    // pc and fetch fsm
    // ************************************************************
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= core_mem_pkg::FETCH_IDLE;
            pc_q         <= RESET_PC;
            redir_pend_q <= 1'b0;
        end else begin
            case (state_q)
                core_mem_pkg::FETCH_IDLE: begin
                    if (redirect_valid_i) begin
                        pc_q <= redirect_pc_i;
                    end
                    state_q <= core_mem_pkg::FETCH_BUS;
                end
                core_mem_pkg::FETCH_BUS: begin
                    if (wb_i.ack) begin
                        redir_pend_q <= 1'b0;
                        // a stale read is thrown away and refetched
                        if (flush) begin
                            pc_q    <= flush_pc;
                            state_q <= core_mem_pkg::FETCH_IDLE;
                        end else begin
                            state_q <= core_mem_pkg::FETCH_HOLD;
                        end
                    end else if (redirect_valid_i) begin
                        redir_pend_q <= 1'b1;
                    end
                end
                core_mem_pkg::FETCH_HOLD: begin
                    if (redirect_valid_i) begin
                        pc_q    <= redirect_pc_i;
                        state_q <= core_mem_pkg::FETCH_BUS;
                    end else if (inst_ready_i) begin
                        pc_q    <= pc_q + 32'd4;
                        state_q <= core_mem_pkg::FETCH_BUS;
                    end
                end
                default: state_q <= core_mem_pkg::FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bus_done) begin
            inst_q <= ack_inst;
        end
        if ((state_q == core_mem_pkg::FETCH_BUS) && redirect_valid_i) begin
            redir_pc_q <= redirect_pc_i;
        end
    end

    // held instruction is dropped by a redirect in the same cycle
    assign inst_valid_o = (state_q == core_mem_pkg::FETCH_HOLD) && !redirect_valid_i;
    assign fetch_o.pc   = pc_q;
    assign fetch_o.inst = inst_q;

    // always a full aligned double-word read
    assign wb_o.cyc = (state_q == core_mem_pkg::FETCH_BUS);
    assign wb_o.stb = (state_q == core_mem_pkg::FETCH_BUS);
    assign wb_o.we  = 1'b0;
    assign wb_o.adr = {pc_q[31:3], 3'b000};
    assign wb_o.sel = 8'hff;
    assign wb_o.dat = '0;

    // address must not move until the slave answers
    a_adr_stable: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (wb_o.stb && !wb_i.ack) |=> $stable(wb_o.adr)
    );

endmodule

//--- source/lsu_unit.sv
module lsu_unit (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   req_valid_i,
    input  core_mem_pkg::lsu_req_t req_i,
    input  core_mem_pkg::wb_rsp_t  wb_i,
    output logic                   req_ready_o,
    output logic                   resp_valid_o,
    output core_mem_pkg::data_t    load_data_o,
    output core_mem_pkg::wb_req_t  wb_o
);

    core_mem_pkg::lsu_state_e state_q;
    core_mem_pkg::lsu_req_t   req_q;
    core_mem_pkg::data_t      load_data_q;
    core_mem_pkg::strb_t      size_mask;
    logic [5:0]               lane_shift;
    core_mem_pkg::data_t      rd_shifted;
    core_mem_pkg::data_t      rd_ext;
    logic [2:0]               align_mask;

    // ************************************************************
    // request fsm
    // ************************************************************
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= core_mem_pkg::LSU_IDLE;
        end else begin
            case (state_q)
                core_mem_pkg::LSU_IDLE: begin
                    if (req_valid_i) begin
                        state_q <= core_mem_pkg::LSU_BUS;
                    end
                end
                core_mem_pkg::LSU_BUS: begin
                    if (wb_i.ack) begin
                        state_q <= core_mem_pkg::LSU_RESP;
                    end
                end
                core_mem_pkg::LSU_RESP: state_q <= core_mem_pkg::LSU_IDLE;
                default:                state_q <= core_mem_pkg::LSU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= req_i;
        end
        if ((state_q == core_mem_pkg::LSU_BUS) && wb_i.ack) begin
            load_data_q <= rd_ext;
        end
    end

    assign req_ready_o  = (state_q == core_mem_pkg::LSU_IDLE);
    assign resp_valid_o = (state_q == core_mem_pkg::LSU_RESP);
    assign load_data_o  = load_data_q;

    // ************************************************************
    // lane alignment
    // ************************************************************
    // byte offset in bits
    assign lane_shift = {req_q.addr[2:0], 3'b000};

    always_comb begin
        case (req_q.size)
            core_mem_pkg::SIZE_BYTE: size_mask = 8'h01;
            core_mem_pkg::SIZE_HALF: size_mask = 8'h03;
            core_mem_pkg::SIZE_WORD: size_mask = 8'h0f;
            default:                 size_mask = 8'hff;
        endcase
    end

    assign wb_o.cyc = (state_q == core_mem_pkg::LSU_BUS);
    assign wb_o.stb = (state_q == core_mem_pkg::LSU_BUS);
    assign wb_o.we  = req_q.we;
    assign wb_o.adr = {req_q.addr[31:3], 3'b000};
    assign wb_o.sel = size_mask << req_q.addr[2:0];
    assign wb_o.dat = req_q.wdata << lane_shift;

    // bring the addressed lanes down to bit 0, then extend
    assign rd_shifted = wb_i.dat >> lane_shift;

    always_comb begin
        case (req_q.size)
            core_mem_pkg::SIZE_BYTE: begin
                rd_ext = req_q.unsigned_ld ? {56'b0, rd_shifted[7:0]}
                                           : {{56{rd_shifted[7]}}, rd_shifted[7:0]};
            end
            core_mem_pkg::SIZE_HALF: begin
                rd_ext = req_q.unsigned_ld ? {48'b0, rd_shifted[15:0]}
                                           : {{48{rd_shifted[15]}}, rd_shifted[15:0]};
            end
            core_mem_pkg::SIZE_WORD: begin
                rd_ext = req_q.unsigned_ld ? {32'b0, rd_shifted[31:0]}
                                           : {{32{rd_shifted[31]}}, rd_shifted[31:0]};
            end
            default: rd_ext = rd_shifted;
        endcase
    end

    // low address bits that must be zero for the size
    always_comb begin
        case (req_i.size)
            core_mem_pkg::SIZE_BYTE: align_mask = 3'b000;
            core_mem_pkg::SIZE_HALF: align_mask = 3'b001;
            core_mem_pkg::SIZE_WORD: align_mask = 3'b011;
            default:                 align_mask = 3'b111;
        endcase
    end

    // The requester only sends naturally aligned accesses.
    a_req_aligned: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (req_valid_i && req_ready_o) |-> ((req_i.addr[2:0] & align_mask) == 3'b000)
    );

endmodule

//--- source/bus_arbiter.sv
module bus_arbiter (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  core_mem_pkg::wb_req_t fetch_req_i,
    input  core_mem_pkg::wb_req_t data_req_i,
    input  core_mem_pkg::wb_rsp_t mem_rsp_i,
    output core_mem_pkg::wb_rsp_t fetch_rsp_o,
    output core_mem_pkg::wb_rsp_t data_rsp_o,
    output core_mem_pkg::wb_req_t mem_req_o
);

    core_mem_pkg::arb_state_e state_q;
    logic                     gnt_fetch;
    logic                     gnt_data;

    // ************************************************************
    // grant with the data port first
    // ************************************************************
    // idle grant is combinational so no cycle is lost
    assign gnt_data  = (state_q == core_mem_pkg::ARB_DATA) ||
                       ((state_q == core_mem_pkg::ARB_IDLE) && data_req_i.cyc);
    assign gnt_fetch = (state_q == core_mem_pkg::ARB_FETCH) ||
                       ((state_q == core_mem_pkg::ARB_IDLE) && !data_req_i.cyc &&
                        fetch_req_i.cyc);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= core_mem_pkg::ARB_IDLE;
        end else begin
            case (state_q)
                core_mem_pkg::ARB_IDLE: begin
                    // a same-cycle ack finishes the transfer at once
                    if (gnt_data && !mem_rsp_i.ack) begin
                        state_q <= core_mem_pkg::ARB_DATA;
                    end else if (gnt_fetch && !mem_rsp_i.ack) begin
                        state_q <= core_mem_pkg::ARB_FETCH;
                    end
                end
                core_mem_pkg::ARB_FETCH,
                core_mem_pkg::ARB_DATA: begin
                    if (mem_rsp_i.ack) begin
                        state_q <= core_mem_pkg::ARB_IDLE;
                    end
                end
                default: state_q <= core_mem_pkg::ARB_IDLE;
            endcase
        end
    end

    // ************************************************************
    // request mux and response routing
    // ************************************************************
    always_comb begin
        if (gnt_data) begin
            mem_req_o = data_req_i;
        end else if (gnt_fetch) begin
            mem_req_o = fetch_req_i;
        end else begin
            mem_req_o = '0;
        end
    end

    assign data_rsp_o.ack  = gnt_data && mem_rsp_i.ack;
    assign data_rsp_o.dat  = gnt_data ? mem_rsp_i.dat : '0;
    assign fetch_rsp_o.ack = gnt_fetch && mem_rsp_i.ack;
    assign fetch_rsp_o.dat = gnt_fetch ? mem_rsp_i.dat : '0;

    // one bus answer goes to exactly one master
    a_ack_onehot: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        mem_rsp_i.ack |-> (fetch_rsp_o.ack != data_rsp_o.ack)
    );

endmodule

//--- source/mem_subsys_top.sv
module mem_subsys_top #(
    parameter core_mem_pkg::addr_t RESET_PC = 32'h8000_0000
) (
    input  logic                     clk,
    input  logic                     arst_n_i,
    // instruction side
    output logic                     inst_valid_o,
    output core_mem_pkg::fetch_out_t fetch_o,
    input  logic                     inst_ready_i,
    input  logic                     redirect_valid_i,
    input  core_mem_pkg::addr_t      redirect_pc_i,
    // data side
    input  logic                     req_valid_i,
    input  core_mem_pkg::lsu_req_t   req_i,
    output logic                     req_ready_o,
    output logic                     resp_valid_o,
    output core_mem_pkg::data_t      load_data_o,
    // memory bus
    output core_mem_pkg::wb_req_t    wb_o,
    input  core_mem_pkg::wb_rsp_t    wb_i
);

    core_mem_pkg::wb_req_t fetch_wb_req;
    core_mem_pkg::wb_rsp_t fetch_wb_rsp;
    core_mem_pkg::wb_req_t lsu_wb_req;
    core_mem_pkg::wb_rsp_t lsu_wb_rsp;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch_unit (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .inst_ready_i     (inst_ready_i),
        .wb_i             (fetch_wb_rsp),
        .inst_valid_o     (inst_valid_o),
        .fetch_o          (fetch_o),
        .wb_o             (fetch_wb_req)
    );

    lsu_unit u_lsu_unit (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .wb_i         (lsu_wb_rsp),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .load_data_o  (load_data_o),
        .wb_o         (lsu_wb_req)
    );

    // both masters share one wishbone port
    bus_arbiter u_bus_arbiter (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .fetch_req_i (fetch_wb_req),
        .data_req_i  (lsu_wb_req),
        .mem_rsp_i   (wb_i),
        .fetch_rsp_o (fetch_wb_rsp),
        .data_rsp_o  (lsu_wb_rsp),
        .mem_req_o   (wb_o)
    );

endmodule

//--- dv/tb_mem_subsys.sv
module tb_mem_subsys;

    localparam core_mem_pkg::addr_t RESET_PC = 32'h8000_0000;

    logic                     clk;
    logic                     arst_n_i;
    logic                     inst_valid_o;
    core_mem_pkg::fetch_out_t fetch_o;
    logic                     inst_ready_i = 1'b0;
    logic                     redirect_valid_i;
    core_mem_pkg::addr_t      redirect_pc_i;
    logic                     req_valid_i;
    core_mem_pkg::lsu_req_t   req_i;
    logic                     req_ready_o;
    logic                     resp_valid_o;
    core_mem_pkg::data_t      load_data_o;
    core_mem_pkg::wb_req_t    wb_o;
    core_mem_pkg::wb_rsp_t    wb_i = '0;

    integer                   seed = 32'hf098_ba05;
    int                       mismatch_count = 0;
    int                       other_count = 0;
    int                       inst_count = 0;
    int                       cycle_count = 0;
    int                       cycle_limit = 1000;
    int                       n_lines = 0;
    int                       mem_wait = 0;
    logic                     mem_busy = 1'b0;
    logic                     lsu_active = 1'b0;
    core_mem_pkg::addr_t      exp_adr;
    core_mem_pkg::strb_t      exp_sel;
    core_mem_pkg::addr_t      exp_pc = RESET_PC;
    core_mem_pkg::fetch_out_t exp_inst;
    logic [7:0]               mem_bytes [core_mem_pkg::addr_t];

    // operation list from the vector file
    logic [63:0]              op_kind [$];
    core_mem_pkg::lsu_size_t  op_size [$];
    logic                     op_uns [$];
    core_mem_pkg::addr_t      op_addr [$];
    core_mem_pkg::data_t      op_wdata [$];
    core_mem_pkg::data_t      op_exp [$];

    mem_subsys_top #(
        .RESET_PC (RESET_PC)
    ) u_mem_subsys_top (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .inst_valid_o     (inst_valid_o),
        .fetch_o          (fetch_o),
        .inst_ready_i     (inst_ready_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .req_valid_i      (req_valid_i),
        .req_i            (req_i),
        .req_ready_o      (req_ready_o),
        .resp_valid_o     (resp_valid_o),
        .load_data_o      (load_data_o),
        .wb_o             (wb_o),
        .wb_i             (wb_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ************************************************************
    // compare tasks
    // ************************************************************
    task automatic check_inst(input core_mem_pkg::fetch_out_t got,
                              input core_mem_pkg::fetch_out_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: fetch pc %h inst %h, expected pc %h inst %h",
                     $time, got.pc, got.inst, exp.pc, exp.inst);
        end
    endtask

    task automatic check_load(input core_mem_pkg::data_t got, input core_mem_pkg::data_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: load data %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_sel(input core_mem_pkg::strb_t got, input core_mem_pkg::strb_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: bus sel %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_adr(input core_mem_pkg::addr_t got, input core_mem_pkg::addr_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: bus adr %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic core_mem_pkg::strb_t lane_sel(input core_mem_pkg::lsu_size_t size,
                                                     input logic [2:0] offset);
        core_mem_pkg::strb_t sel;
        int                  nbytes;
        nbytes = 1 << size;
        // one lane per accessed byte from the offset up
        for (int i = 0; i < 8; i++) begin
            sel[i] = (i >= offset) && (i < offset + nbytes);
        end
        return sel;
    endfunction

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    endtask

    // ************************************************************
    // wishbone memory model and ready throttle
    // ************************************************************
    task automatic serve_access();
        core_mem_pkg::addr_t a;
        core_mem_pkg::data_t fill;
        core_mem_pkg::data_t rd;
        a    = wb_o.adr;
        // unwritten double word reads back its own address pair
        fill = {a + 32'd4, a};
        if (wb_o.we || (a[31:28] != 4'h8)) begin
            if (!lsu_active) begin
                other_count++;
                $display("data bus cycle at %0t with no data request outstanding", $time);
            end else begin
                check_adr(a, exp_adr);
                check_sel(wb_o.sel, exp_sel);
            end
        end
        for (int i = 0; i < 8; i++) begin
            if (wb_o.we && wb_o.sel[i]) begin
                mem_bytes[a + 32'(i)] = wb_o.dat[8*i +: 8];
            end
            rd[8*i +: 8] = mem_bytes.exists(a + 32'(i)) ? mem_bytes[a + 32'(i)] : fill[8*i +: 8];
        end
        wb_i.ack = 1'b1;
        wb_i.dat = wb_o.we ? '0 : rd;
    endtask

    always @(negedge clk) begin
        if (!arst_n_i) begin
            inst_ready_i = 1'b0;
            wb_i         = '0;
            mem_busy     = 1'b0;
        end else begin
            // ready in about three cycles of four
            inst_ready_i = ($random(seed) & 3) != 0;
            if (wb_i.ack) begin
                wb_i = '0;
            end else if (wb_o.cyc && wb_o.stb) begin
                if (!mem_busy) begin
                    mem_busy = 1'b1;
                    mem_wait = $random(seed) & 3;
                end
                if (mem_wait == 0) begin
                    serve_access();
                    mem_busy = 1'b0;
                end else begin
                    mem_wait--;
                end
            end
        end
    end

    // instruction stream monitor on the rising edge
    always @(posedge clk) begin
        if (arst_n_i && inst_valid_o && inst_ready_i) begin
            exp_inst.pc   = exp_pc;
            exp_inst.inst = exp_pc;
            check_inst(fetch_o, exp_inst);
            exp_pc = exp_pc + 32'd4;
            inst_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            print_counts();
            $display("TEST FAILED");
            $finish;
        end
    end

    // ************************************************************
    // stimulus
    // ************************************************************
    task automatic read_vectors(input int fd);
        string                   line;
        int                      n;
        logic [63:0]             kind_v;
        core_mem_pkg::lsu_size_t size_v;
        logic                    uns_v;
        core_mem_pkg::addr_t     addr_v;
        core_mem_pkg::data_t     wdata_v;
        core_mem_pkg::data_t     exp_v;
        while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
                n_lines++;
                if (line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h",
                                kind_v, size_v, uns_v, addr_v, wdata_v, exp_v);
                    if (n == 6) begin
                        op_kind.push_back(kind_v);
                        op_size.push_back(size_v);
                        op_uns.push_back(uns_v);
                        op_addr.push_back(addr_v);
                        op_wdata.push_back(wdata_v);
                        op_exp.push_back(exp_v);
                    end
                end
            end
        end
    endtask

    task automatic run_lsu_op(input int idx);
        core_mem_pkg::lsu_req_t req;
        req.we          = (op_kind[idx] == 64'("store"));
        req.size        = op_size[idx];
        req.unsigned_ld = op_uns[idx];
        req.addr        = op_addr[idx];
        req.wdata       = op_wdata[idx];
        while (!req_ready_o) begin
            @(negedge clk);
        end
        exp_adr     = {req.addr[31:3], 3'b000};
        exp_sel     = lane_sel(req.size, req.addr[2:0]);
        lsu_active  = 1'b1;
        req_valid_i = 1'b1;
        req_i       = req;
        @(negedge clk);
        req_valid_i = 1'b0;
        while (!resp_valid_o) begin
            @(negedge clk);
        end
        lsu_active = 1'b0;
        if (!req.we) begin
            check_load(load_data_o, op_exp[idx]);
        end
    endtask

    task automatic run_redirect(input core_mem_pkg::addr_t pc);
        redirect_valid_i = 1'b1;
        redirect_pc_i    = pc;
        exp_pc           = pc;
        @(negedge clk);
        redirect_valid_i = 1'b0;
    endtask

    initial begin
        int fd;
        arst_n_i         = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        req_valid_i      = 1'b0;
        req_i            = '0;
        fd = $fopen("dv/lsu_input_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file dv/lsu_input_vectors.txt");
            other_count++;
            print_counts();
            $display("TEST FAILED");
            $finish;
        end else begin
            read_vectors(fd);
            $fclose(fd);
            cycle_limit = 200 * n_lines + 500;
            repeat (16) @(negedge clk);
            check_flag(wb_o.cyc, 1'b0, "wb_o.cyc in reset");
            check_flag(inst_valid_o, 1'b0, "inst_valid_o in reset");
            check_flag(resp_valid_o, 1'b0, "resp_valid_o in reset");
            check_flag(req_ready_o, 1'b1, "req_ready_o in reset");
            arst_n_i = 1'b1;
            foreach (op_kind[i]) begin
                if (op_kind[i] == 64'("redirect")) begin
                    run_redirect(op_addr[i]);
                end else if ((op_kind[i] == 64'("load")) || (op_kind[i] == 64'("store"))) begin
                    run_lsu_op(i);
                end else begin
                    other_count++;
                    $display("unknown operation kind on vector %0d", i);
                end
            end
            // let the fetch stream run on for a while
            repeat (40) @(negedge clk);
            if (inst_count < 8) begin
                other_count++;
                $display("only %0d instructions were delivered", inst_count);
            end
            print_counts();
            if ((mismatch_count == 0) && (other_count == 0)) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

//--- dv/lsu_input_vectors.txt
# kind size(0 byte,1 half,2 word,3 double) unsigned addr wdata expected_load
# redirect lines carry the new pc in the addr column
store    3 0 00002000 8877665544332211 0000000000000000
load     3 0 00002000 0000000000000000 8877665544332211
load     0 0 00002007 0000000000000000 ffffffffffffff88
load     0 1 00002007 0000000000000000 0000000000000088
load     1 0 00002006 0000000000000000 ffffffffffff8877
load     1 1 00002002 0000000000000000 0000000000004433
load     2 0 00002004 0000000000000000 ffffffff88776655
load     2 1 00002004 0000000000000000 0000000088776655
store    0 0 00002001 00000000000000a5 0000000000000000
store    1 0 00002004 000000000000beef 0000000000000000
redirect 0 0 80000100 0000000000000000 0000000000000000
load     3 0 00002000 0000000000000000 8877beef4433a511
store    2 0 0000200c 00000000cafe1234 0000000000000000
load     3 0 00002008 0000000000000000 cafe123400002008
load     2 0 0000200c 0000000000000000 ffffffffcafe1234
load     1 0 00002008 0000000000000000 0000000000002008
load     0 0 00002015 0000000000000000 0000000000000020
redirect 0 0 80000040 0000000000000000 0000000000000000
store    0 0 00002017 0000000000000080 0000000000000000
load     0 0 00002017 0000000000000000 ffffffffffffff80
load     2 1 00002014 0000000000000000 0000000080002014
load     2 0 00002010 0000000000000000 0000000000002010

//--- compile.f
source/core_mem_pkg.sv
source/fetch_unit.sv
source/lsu_unit.sv
source/bus_arbiter.sv
source/mem_subsys_top.sv
dv/tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_mem_subsys \
    -f compile.f \
    -o sim_mem_subsys

./obj_dir/sim_mem_subsys | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
    exit 0
fi

echo "simulation did not pass, see sim.log"
exit 1
